/* gat_debugger.f */
hw/dbg_pkg.sv
hw/stage_flag_monitor.sv
hw/feat_write_watch.sv
hw/pe_probe_capture.sv
hw/debug_word_mux.sv
hw/gat_debugger.sv
sim/tb_gat_debugger.sv

/* Bender.yml */
package:
  name: gat_debugger

sources:
  - hw/dbg_pkg.sv
  - hw/stage_flag_monitor.sv
  - hw/feat_write_watch.sv
  - hw/pe_probe_capture.sv
  - hw/debug_word_mux.sv
  - hw/gat_debugger.sv
  - target: simulation
    files:
      - sim/tb_gat_debugger.sv

/* sim/tb_gat_debugger.sv */
`timescale 1ns/1ns

module tb_gat_debugger;

  localparam int NUM_CYCLES    = 3000;
  localparam int RESET_TIMEOUT = 20;
  localparam int RUN_TIMEOUT   = 2 * NUM_CYCLES + 100;
  localparam int BUSY_CLEAR_AT = 250; // Cycle within each 500 that forces a loaded clear

  logic                          clk;
  logic                          rst_n;
  dbg_pkg::stage_strobe_t        stage;
  dbg_pkg::feat_wr_t             feat_wr;
  logic [dbg_pkg::WH_ADDR_W-1:0] wh_addr;
  dbg_pkg::sppe_bus_t            sppe;
  logic                          clear;
  dbg_pkg::dbg_sel_e             dbg_sel;
  dbg_pkg::dbg_word_t            debug_word;
  dbg_pkg::stage_strobe_t        debug_flags;
  logic                          run_done;

  // Reference model state
  dbg_pkg::stage_strobe_t        m_flags;
  dbg_pkg::dbg_word_t            m_sm_count;
  logic                          m_ena_seen;
  logic                          m_over_seen;
  logic [15:0]                   m_wr_count;
  logic [dbg_pkg::FEAT_ADDR_W-1:0] m_over_addr;
  logic [dbg_pkg::PE_W-1:0]      m_probe_a;
  logic [dbg_pkg::PE_W-1:0]      m_probe_b;

  gat_debugger i_gat_debugger (
    .clk           (clk),
    .rst_n         (rst_n),
    .stage_i       (stage),
    .feat_wr_i     (feat_wr),
    .wh_addr_i     (wh_addr),
    .sppe_i        (sppe),
    .clear_i       (clear),
    .dbg_sel_i     (dbg_sel),
    .debug_word_o  (debug_word),
    .debug_flags_o (debug_flags)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  task automatic check_word(input string name, input dbg_pkg::dbg_word_t exp,
                            input dbg_pkg::dbg_word_t act);
    if (act !== exp) begin
      $display("ERR %s expected %08h actual %08h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "Debug word mismatch");
    end
  endtask

  task automatic check_flags(input string name, input dbg_pkg::stage_strobe_t exp,
                             input dbg_pkg::stage_strobe_t act);
    if (act !== exp) begin
      $display("ERR %s expected %02h actual %02h", name, exp, act);
      $display("Test FAILED");
      $fatal(1, "Stage flag mismatch");
    end
  endtask

  task automatic clear_model();
    m_flags     = '0;
    m_sm_count  = '0;
    m_ena_seen  = 1'b0;
    m_over_seen = 1'b0;
    m_wr_count  = '0;
    m_over_addr = '0;
    m_probe_a   = '0;
    m_probe_b   = '0;
  endtask

  // Applies the inputs sampled at this rising edge
  task automatic update_model();
    if (clear) begin
      clear_model();
    end else begin
      m_flags = m_flags | stage;
      if (stage.sm_vld) begin
        m_sm_count = m_sm_count + 32'd1;
      end
      if (feat_wr.ena) begin
        m_ena_seen = 1'b1;
        m_wr_count = m_wr_count + 16'd1;
        if (feat_wr.addr >= dbg_pkg::FEAT_ADDR_LIMIT) begin
          if (!m_over_seen) begin
            m_over_addr = feat_wr.addr; // Only the first violation is recorded
          end
          m_over_seen = 1'b1;
        end
      end
      if (stage.spmm_rdy && wh_addr == dbg_pkg::PROBE_ADDR_A) begin
        m_probe_a = sppe[dbg_pkg::PROBE_LANE];
      end
      if (stage.spmm_rdy && wh_addr == dbg_pkg::PROBE_ADDR_B) begin
        m_probe_b = sppe[dbg_pkg::PROBE_LANE];
      end
    end
  endtask

  function automatic dbg_pkg::dbg_word_t expected_word(input dbg_pkg::dbg_sel_e sel);
    dbg_pkg::dbg_word_t w;
    case (sel)
      dbg_pkg::SEL_ID:             w = 32'd19461604;
      dbg_pkg::SEL_NUM_SPARSE:     w = 32'd12;
      dbg_pkg::SEL_FLAGS:          w = {24'd0, m_flags};
      dbg_pkg::SEL_SM_COUNT:       w = m_sm_count;
      dbg_pkg::SEL_PROBE_A:        w = {20'd0, m_probe_a};
      dbg_pkg::SEL_PROBE_B:        w = {20'd0, m_probe_b};
      dbg_pkg::SEL_FEAT_STATUS:    w = {m_wr_count, 14'd0, m_over_seen, m_ena_seen};
      dbg_pkg::SEL_FEAT_OVER_ADDR: w = {16'd0, m_over_addr};
      default:                     w = '0;
    endcase
    return w;
  endfunction

  // Walks the select through all words while the registers are stable
  task automatic sweep_and_check(input string tag);
    dbg_pkg::dbg_sel_e sel;
    check_flags($sformatf("%s debug_flags_o", tag), m_flags, debug_flags);
    for (int s = 0; s < 8; s++) begin
      sel     = dbg_pkg::dbg_sel_e'(s);
      dbg_sel = sel;
      #4;
      check_word($sformatf("%s %s", tag, sel.name()), expected_word(sel), debug_word);
      #1;
    end
  endtask

  task automatic drive_random();
    logic [7:0] strobe_bits;
    for (int i = 0; i < 8; i++) begin
      strobe_bits[i] = ($urandom_range(99) < 10);
    end
    stage       = strobe_bits;
    feat_wr.ena = ($urandom_range(99) < 30);
    if ($urandom_range(3) == 0) begin
      feat_wr.addr = $urandom_range(16'hFFFF, 43328); // Over-limit region
    end else begin
      feat_wr.addr = $urandom_range(43327, 0);
    end
    feat_wr.din = $urandom;
    if ($urandom_range(9) != 0) begin
      wh_addr = $urandom_range(31);
    end else begin
      wh_addr = $urandom;
    end
    for (int i = 0; i < dbg_pkg::NUM_PE; i++) begin
      sppe[i] = $urandom;
    end
    clear = ($urandom_range(99) == 0);
  endtask

  // Clear lands on a cycle full of events that must all be dropped
  task automatic drive_busy_clear();
    stage        = 8'hFF;
    feat_wr.ena  = 1'b1;
    feat_wr.addr = 16'hFFFF;
    wh_addr      = dbg_pkg::PROBE_ADDR_A;
    clear        = 1'b1;
  endtask

  // Inputs for one cycle, sampled at the next rising edge
  task automatic drive_cycle(input int cyc);
    drive_random();
    if (cyc % 500 == BUSY_CLEAR_AT) begin
      drive_busy_clear();
    end
  endtask

  initial begin
    int wait_cnt;
    void'($urandom(81573));
    run_done     = 1'b0;
    stage        = '0;
    feat_wr      = '0;
    wh_addr      = '0;
    sppe         = '0;
    clear        = 1'b0;
    dbg_sel      = dbg_pkg::SEL_ID;
    clear_model();

    wait_cnt = 0;
    @(posedge clk);
    while (!rst_n && wait_cnt < RESET_TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (!rst_n) begin
      $display("Timeout waiting for reset release");
      $display("Test FAILED");
      $fatal(1, "Reset never released");
    end

    @(negedge clk);
    drive_cycle(0);
    sweep_and_check("after_reset");

    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      @(posedge clk);
      update_model();
      @(negedge clk);
      drive_cycle(cyc + 1);
      sweep_and_check($sformatf("cycle %0d", cyc));
    end

    run_done = 1'b1;
    $display("Test OK");
    $finish;
  end

  initial begin
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (!run_done && cycles < RUN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!run_done) begin
      $display("Timeout waiting for the random run to finish");
      $display("Test FAILED");
      $fatal(1, "Run did not complete");
    end
  end

endmodule

/* hw/gat_debugger.sv */
`timescale 1ns/1ns

module gat_debugger (
  input  logic                          clk,
  input  logic                          rst_n,
  input  dbg_pkg::stage_strobe_t        stage_i,
  input  dbg_pkg::feat_wr_t             feat_wr_i,
  input  logic [dbg_pkg::WH_ADDR_W-1:0] wh_addr_i,
  input  dbg_pkg::sppe_bus_t            sppe_i,
  input  logic                          clear_i,
  input  dbg_pkg::dbg_sel_e             dbg_sel_i,
  output dbg_pkg::dbg_word_t            debug_word_o,
  output dbg_pkg::stage_strobe_t        debug_flags_o
);

  dbg_pkg::stage_strobe_t flags;
  dbg_pkg::dbg_word_t     sm_count;
  dbg_pkg::dbg_word_t     feat_status;
  dbg_pkg::dbg_word_t     feat_over_addr;
  dbg_pkg::dbg_word_t     probe_a;
  dbg_pkg::dbg_word_t     probe_b;

  stage_flag_monitor i_stage_flag_monitor (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear_i),
    .stage_i    (stage_i),
    .flags_o    (flags),
    .sm_count_o (sm_count)
  );

  feat_write_watch i_feat_write_watch (
    .clk         (clk),
    .rst_n       (rst_n),
    .clear_i     (clear_i),
    .feat_wr_i   (feat_wr_i),
    .status_o    (feat_status),
    .over_addr_o (feat_over_addr)
  );

  // Probes fire only while spmm reports ready
  pe_probe_capture i_pe_probe_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (clear_i),
    .spmm_rdy_i (stage_i.spmm_rdy),
    .wh_addr_i  (wh_addr_i),
    .sppe_i     (sppe_i),
    .probe_a_o  (probe_a),
    .probe_b_o  (probe_b)
  );

  debug_word_mux i_debug_word_mux (
    .dbg_sel_i        (dbg_sel_i),
    .flags_i          (flags),
    .sm_count_i       (sm_count),
    .feat_status_i    (feat_status),
    .feat_over_addr_i (feat_over_addr),
    .probe_a_i        (probe_a),
    .probe_b_i        (probe_b),
    .debug_word_o     (debug_word_o)
  );

  assign debug_flags_o = flags; // Flags are always visible, whatever the select

endmodule

/* hw/debug_word_mux.sv */
`timescale 1ns/1ns

module debug_word_mux (
  input  dbg_pkg::dbg_sel_e      dbg_sel_i,
  input  dbg_pkg::stage_strobe_t flags_i,
  input  dbg_pkg::dbg_word_t     sm_count_i,
  input  dbg_pkg::dbg_word_t     feat_status_i,
  input  dbg_pkg::dbg_word_t     feat_over_addr_i,
  input  dbg_pkg::dbg_word_t     probe_a_i,
  input  dbg_pkg::dbg_word_t     probe_b_i,
  output dbg_pkg::dbg_word_t     debug_word_o
);

  dbg_pkg::dbg_word_t flags_word;

  assign flags_word = {{(32-$bits(dbg_pkg::stage_strobe_t)){1'b0}}, flags_i};

  always_comb begin
    case (dbg_sel_i)
      dbg_pkg::SEL_ID: begin
        debug_word_o = dbg_pkg::DBG_ID;
      end
      dbg_pkg::SEL_NUM_SPARSE: begin
        debug_word_o = dbg_pkg::H_NUM_SPARSE_DATA;
      end
      dbg_pkg::SEL_FLAGS: begin
        debug_word_o = flags_word;
      end
      dbg_pkg::SEL_SM_COUNT: begin
        debug_word_o = sm_count_i;
      end
      dbg_pkg::SEL_PROBE_A: begin
        debug_word_o = probe_a_i;
      end
      dbg_pkg::SEL_PROBE_B: begin
        debug_word_o = probe_b_i;
      end
      dbg_pkg::SEL_FEAT_STATUS: begin
        debug_word_o = feat_status_i;
      end
      dbg_pkg::SEL_FEAT_OVER_ADDR: begin
        debug_word_o = feat_over_addr_i;
      end
      default: begin
        debug_word_o = '0; // Unknown select reads as zero
      end
    endcase
  end

endmodule

/* hw/pe_probe_capture.sv */
`timescale 1ns/1ns

module pe_probe_capture (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          clear_i,
  input  logic                          spmm_rdy_i,
  input  logic [dbg_pkg::WH_ADDR_W-1:0] wh_addr_i,
  input  dbg_pkg::sppe_bus_t            sppe_i,
  output dbg_pkg::dbg_word_t            probe_a_o,
  output dbg_pkg::dbg_word_t            probe_b_o
);

  logic [dbg_pkg::PE_W-1:0] lane;
  logic                     hit_a;
  logic                     hit_b;
  logic [dbg_pkg::PE_W-1:0] probe_a_q;
  logic [dbg_pkg::PE_W-1:0] probe_b_q;

  assign lane  = sppe_i[dbg_pkg::PROBE_LANE];
  assign hit_a = spmm_rdy_i && (wh_addr_i == dbg_pkg::PROBE_ADDR_A);
  assign hit_b = spmm_rdy_i && (wh_addr_i == dbg_pkg::PROBE_ADDR_B);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      probe_a_q <= '0;
    end else if (clear_i) begin
      probe_a_q <= '0;
    end else if (hit_a) begin
      probe_a_q <= lane; // Newest hit replaces the older capture
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      probe_b_q <= '0;
    end else if (clear_i) begin
      probe_b_q <= '0;
    end else if (hit_b) begin
      probe_b_q <= lane;
    end
  end

  assign probe_a_o = {{(32-dbg_pkg::PE_W){1'b0}}, probe_a_q};
  assign probe_b_o = {{(32-dbg_pkg::PE_W){1'b0}}, probe_b_q};

endmodule

/* hw/feat_write_watch.sv */
`timescale 1ns/1ns

module feat_write_watch (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               clear_i,
  input  dbg_pkg::feat_wr_t  feat_wr_i,
  output dbg_pkg::dbg_word_t status_o,
  output dbg_pkg::dbg_word_t over_addr_o
);

  logic                            over_hit;
  logic                            ena_seen_q;
  logic                            over_seen_q;
  logic [15:0]                     wr_count_q;
  logic [dbg_pkg::FEAT_ADDR_W-1:0] over_addr_q;

  // Write that lands at or beyond the legal limit
  assign over_hit = feat_wr_i.ena && (feat_wr_i.addr >= dbg_pkg::FEAT_ADDR_LIMIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ena_seen_q  <= 1'b0;
      over_seen_q <= 1'b0;
      wr_count_q  <= '0;
    end else if (clear_i) begin
      ena_seen_q  <= 1'b0;
      over_seen_q <= 1'b0;
      wr_count_q  <= '0;
    end else begin
      if (feat_wr_i.ena) begin
        ena_seen_q <= 1'b1;
        wr_count_q <= wr_count_q + 16'd1; // Wrapping write count
      end
      if (over_hit) begin
        over_seen_q <= 1'b1;
      end
    end
  end

  // Only the first violation is kept, later ones leave it alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      over_addr_q <= '0;
    end else if (clear_i) begin
      over_addr_q <= '0;
    end else if (over_hit && !over_seen_q) begin
      over_addr_q <= feat_wr_i.addr;
    end
  end

  always_comb begin
    status_o        = '0;
    status_o[31:16] = wr_count_q;
    status_o[1]     = over_seen_q;
    status_o[0]     = ena_seen_q;
  end

  assign over_addr_o = {{(32-dbg_pkg::FEAT_ADDR_W){1'b0}}, over_addr_q};

endmodule

/* hw/stage_flag_monitor.sv */
`timescale 1ns/1ns

module stage_flag_monitor (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   clear_i,
  input  dbg_pkg::stage_strobe_t stage_i,
  output dbg_pkg::stage_strobe_t flags_o,
  output dbg_pkg::dbg_word_t     sm_count_o
);

  dbg_pkg::stage_strobe_t flags_q;
  dbg_pkg::stage_strobe_t flags_d;
  dbg_pkg::dbg_word_t     sm_count_q;
  dbg_pkg::dbg_word_t     sm_count_d;

  // A flag once set only falls on clear
  always_comb begin
    flags_d = flags_q | stage_i;
    if (clear_i) begin
      flags_d = '0; // Clear wins over strobes in the same cycle
    end
  end

  always_comb begin
    sm_count_d = sm_count_q;
    if (clear_i) begin
      sm_count_d = '0;
    end else if (stage_i.sm_vld) begin
      sm_count_d = sm_count_q + 32'd1; // Wraps at 2^32
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_d;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
    end else begin
      sm_count_q <= sm_count_d;
    end
  end

  assign flags_o    = flags_q;
  assign sm_count_o = sm_count_q;

endmodule

/* hw/dbg_pkg.sv */
package dbg_pkg;

  localparam int NUM_PE      = 16;
  localparam int PE_W        = 12;
  localparam int FEAT_ADDR_W = 16;
  localparam int WH_ADDR_W   = 14;
  localparam int PROBE_LANE  = 2; // Sparse PE lane watched by both probes

  typedef logic [31:0] dbg_word_t;

  // First feature address outside the legal buffer region
  localparam logic [FEAT_ADDR_W-1:0] FEAT_ADDR_LIMIT = 16'd43328;

  localparam logic [WH_ADDR_W-1:0] PROBE_ADDR_A = 14'd10;
  localparam logic [WH_ADDR_W-1:0] PROBE_ADDR_B = 14'd20;

  localparam dbg_word_t H_NUM_SPARSE_DATA = 32'd12;
  localparam dbg_word_t DBG_ID            = 32'd19461604; // Fixed identity of this debug block

  // One bit per stage strobe, also reused for the sticky flags
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_strobe_t;

  typedef struct packed {
    logic                   ena;
    logic [FEAT_ADDR_W-1:0] addr;
    logic [31:0]            din;
  } feat_wr_t;

  typedef logic [NUM_PE-1:0][PE_W-1:0] sppe_bus_t;

  typedef enum logic [2:0] {
    SEL_ID             = 3'd0,
    SEL_NUM_SPARSE     = 3'd1,
    SEL_FLAGS          = 3'd2,
    SEL_SM_COUNT       = 3'd3,
    SEL_PROBE_A        = 3'd4,
    SEL_PROBE_B        = 3'd5,
    SEL_FEAT_STATUS    = 3'd6,
    SEL_FEAT_OVER_ADDR = 3'd7
  } dbg_sel_e;

endpackage
